/* all.f */
src/chip_bus_pkg.sv
src/chipset_regs_pkg.sv
src/dma_bus_if.sv
src/beam_slot_counter.sv
src/dma_control.sv
src/bus_arbiter.sv
src/agnus_top.sv
dv/tb_agnus.sv

/* dv/tb_agnus.sv */
`timescale 1ns/1ps

module tb_agnus;
  import chip_bus_pkg::*;
  import chipset_regs_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int TEST_CYCLES = 1100;  // sum of all phases, rounded up
  localparam int MARGIN      = 400;

  logic              clk;
  logic              reset;
  logic              aen, rd, hwr, lwr;        // cpu bus cycle
  reg_addr_t         address_in;
  data_word_t        data_in;
  data_word_t        data_out;
  chip_addr_t        address_out;
  reg_addr_t         reg_address_out;
  logic              cpu_custom, dbr, dbwe, bltpri;
  logic [HPOS_W-1:0] hpos;
  logic              blit_busy, blit_zero, bls, turbo;
  logic              dsk_dma, dsk_wr, aud_dma, bpl_dma;
  logic              spr_req, cop_req, blt_req, blt_we;
  logic              spr_ack, cop_ack, blt_ack;
  chip_addr_t        dsk_address, aud_address, bpl_address;
  chip_addr_t        spr_address, cop_address, blt_address;
  reg_addr_t         dsk_reg_address, aud_reg_address, bpl_reg_address;
  reg_addr_t         spr_reg_address, cop_reg_address, blt_reg_address;

  // reference model state
  logic [HPOS_W-1:0]   m_hpos;
  logic [DMACON_W-1:0] m_dmacon;
  int                  m_bls_cnt;                 // missed cpu cycles
  int                  ref_off;                   // slot distance from first refresh
  logic                m_refresh, m_hold;
  logic                m_bplen, m_copen, m_blten, m_spren;
  reg_addr_t           m_cpu_reg;
  dma_chan_e           m_owner;
  chip_addr_t          exp_addr;
  reg_addr_t           exp_reg;
  logic                exp_we;
  data_word_t          exp_data;
  integer              seed = 29;
  int                  errors = 0;

  agnus_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------

  always_comb begin
    ref_off   = int'(m_hpos) - REFRESH_SLOT_FIRST;
    m_refresh = (ref_off >= 0) && (ref_off < 2 * REFRESH_SLOT_COUNT) && (ref_off % 2 == 0);
    m_bplen   = m_dmacon[DMAEN_BIT] && m_dmacon[BPLEN_BIT];
    m_copen   = m_dmacon[DMAEN_BIT] && m_dmacon[COPEN_BIT];
    m_blten   = m_dmacon[DMAEN_BIT] && m_dmacon[BLTEN_BIT];
    m_spren   = m_dmacon[DMAEN_BIT] && m_dmacon[SPREN_BIT];
    m_hold    = (m_bls_cnt == BLS_CNT_MAX);
    m_cpu_reg = (aen && (rd || hwr || lwr)) ? address_in : REG_IDLE;
    if (dsk_dma)                          m_owner = CHAN_DSK;
    else if (m_refresh)                   m_owner = CHAN_REF;
    else if (aud_dma)                     m_owner = CHAN_AUD;
    else if (bpl_dma && m_bplen)          m_owner = CHAN_BPL;
    else if (spr_req && m_spren)          m_owner = CHAN_SPR;
    else if (cop_req && m_copen)          m_owner = CHAN_COP;
    else if (blt_req && m_blten && !m_hold) m_owner = CHAN_BLT;
    else                                  m_owner = CHAN_CPU;
    exp_addr = '0;
    exp_reg  = REG_IDLE;                  // refresh keeps these
    exp_we   = 1'b0;
    case (m_owner)
      CHAN_DSK: {exp_addr, exp_reg, exp_we} = {dsk_address, dsk_reg_address, dsk_wr};
      CHAN_AUD: {exp_addr, exp_reg} = {aud_address, aud_reg_address};
      CHAN_BPL: {exp_addr, exp_reg} = {bpl_address, bpl_reg_address};
      CHAN_SPR: {exp_addr, exp_reg} = {spr_address, spr_reg_address};
      CHAN_COP: {exp_addr, exp_reg} = {cop_address, cop_reg_address};
      CHAN_BLT: {exp_addr, exp_reg, exp_we} = {blt_address, blt_reg_address, blt_we};
      CHAN_CPU: exp_reg = m_cpu_reg;
      default:  exp_reg = REG_IDLE;
    endcase
    exp_data = (exp_reg == DMACONR_ADDR) ? {1'b0, blit_busy, blit_zero, m_dmacon} : 16'h0000;
  end

  always @(posedge clk) begin
    if (reset) begin
      m_hpos    <= '0;
      m_dmacon  <= '0;
      m_bls_cnt <= 0;
    end else begin
      m_hpos <= (m_hpos == HPOS_W'(LINE_SLOTS - 1)) ? '0 : m_hpos + 1'b1;
      if (exp_reg == DMACON_ADDR) begin
        if (data_in[SETCLR_BIT])
          m_dmacon <= m_dmacon | data_in[DMACON_W-1:0];
        else
          m_dmacon <= m_dmacon & ~data_in[DMACON_W-1:0];
      end
      if (!m_hpos[0] || turbo) begin     // colour clock phase or turbo
        if (!bls || m_dmacon[BLTPRI_BIT])
          m_bls_cnt <= 0;
        else if (m_bls_cnt < BLS_CNT_MAX)
          m_bls_cnt <= m_bls_cnt + 1;
      end
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  a_hpos: assert property (@(posedge clk) disable iff (reset) hpos == m_hpos)
    else report_mismatch("hpos differs from model");
  a_addr: assert property (@(posedge clk) disable iff (reset) address_out == exp_addr)
    else report_mismatch("address_out wrong for bus owner");
  a_reg: assert property (@(posedge clk) disable iff (reset) reg_address_out == exp_reg)
    else report_mismatch("reg_address_out wrong for bus owner");
  a_dbr: assert property (@(posedge clk) disable iff (reset) dbr == (m_owner != CHAN_CPU))
    else report_mismatch("dbr wrong");
  a_cpu: assert property (@(posedge clk) disable iff (reset)
    cpu_custom == (m_owner == CHAN_CPU)) else report_mismatch("cpu_custom wrong");
  a_we: assert property (@(posedge clk) disable iff (reset) dbwe == exp_we)
    else report_mismatch("dbwe wrong");
  a_spr: assert property (@(posedge clk) disable iff (reset) spr_ack == (m_owner == CHAN_SPR))
    else report_mismatch("spr_ack wrong");
  a_cop: assert property (@(posedge clk) disable iff (reset) cop_ack == (m_owner == CHAN_COP))
    else report_mismatch("cop_ack wrong");
  a_blt: assert property (@(posedge clk) disable iff (reset) blt_ack == (m_owner == CHAN_BLT))
    else report_mismatch("blt_ack wrong");
  a_data: assert property (@(posedge clk) disable iff (reset) data_out == exp_data)
    else report_mismatch("data_out readback wrong");
  a_pri: assert property (@(posedge clk) disable iff (reset) bltpri == m_dmacon[BLTPRI_BIT])
    else report_mismatch("bltpri differs from DMACON");
  // an ack never comes without its own request
  a_spr_req: assert property (@(posedge clk) disable iff (reset) spr_ack |-> spr_req)
    else report_mismatch("spr_ack without spr_req");
  a_cop_req: assert property (@(posedge clk) disable iff (reset) cop_ack |-> cop_req)
    else report_mismatch("cop_ack without cop_req");
  a_blt_req: assert property (@(posedge clk) disable iff (reset) blt_ack |-> blt_req)
    else report_mismatch("blt_ack without blt_req");

  // ------------------------------------------------------------------
  // stimulus tasks, called right after a rising edge
  // ------------------------------------------------------------------

  task automatic clear_requests();
    {aen, rd, hwr, lwr, blit_busy, blit_zero, bls, turbo} <= '0;
    {dsk_dma, dsk_wr, aud_dma, bpl_dma, spr_req, cop_req, blt_req, blt_we} <= '0;
    address_in <= '0;
    data_in    <= '0;
    {dsk_address, aud_address, bpl_address} <= '0;
    {spr_address, cop_address, blt_address} <= '0;
    {dsk_reg_address, aud_reg_address, bpl_reg_address} <= '0;
    {spr_reg_address, cop_reg_address, blt_reg_address} <= '0;
  endtask

  // held two cycles so one of them misses the odd refresh slots
  task automatic cpu_access(input logic write_op, input reg_addr_t addr, input data_word_t data);
    @(posedge clk);
    aen        <= 1'b1;
    rd         <= !write_op;
    hwr        <= write_op;
    lwr        <= write_op;
    address_in <= addr;
    data_in    <= data;
    repeat (2) @(posedge clk);
    {aen, rd, hwr, lwr} <= '0;
    data_in <= '0;
  endtask

  task automatic randomize_requests();
    logic [31:0] r;
    r = $random(seed);
    dsk_dma    <= (r[2:0] == 3'd0);      // disk and audio stay sparse
    aud_dma    <= (r[5:3] == 3'd0);
    bpl_dma    <= (r[7:6] == 2'd0);
    {spr_req, cop_req, blt_req, dsk_wr, blt_we, bls} <= r[13:8];
    turbo      <= (r[15:14] == 2'd0);
    {aen, rd, hwr, lwr, blit_busy, blit_zero} <= r[21:16];
    address_in <= r[29:22];
    r = $random(seed);
    data_in    <= r[15:0];
    r = $random(seed);
    {dsk_reg_address, dsk_address} <= r[27:0];
    r = $random(seed);
    {aud_reg_address, aud_address} <= r[27:0];
    r = $random(seed);
    {bpl_reg_address, bpl_address} <= r[27:0];
    r = $random(seed);
    {spr_reg_address, spr_address} <= r[27:0];
    r = $random(seed);
    {cop_reg_address, cop_address} <= r[27:0];
    r = $random(seed);
    {blt_reg_address, blt_address} <= r[27:0];
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    reset = 1'b1;
    clear_requests();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // idle bus, then cpu reads at random addresses
    repeat (4) @(posedge clk);
    repeat (6) begin
      r = $random(seed);
      cpu_access(1'b0, r[7:0], r[23:8]);
    end
    // DMACON set and clear with readback
    cpu_access(1'b1, DMACON_ADDR, 16'h83E0);   // master, bpl, cop, blt, spr
    blit_busy <= 1'b1;
    cpu_access(1'b0, DMACONR_ADDR, 16'h0000);
    cpu_access(1'b1, DMACON_ADDR, 16'h0140);   // clear bpl and blt
    blit_zero <= 1'b1;
    cpu_access(1'b0, DMACONR_ADDR, 16'h0000);
    cpu_access(1'b1, DMACON_ADDR, 16'h8400);   // set bltpri
    cpu_access(1'b0, DMACONR_ADDR, 16'h0000);
    cpu_access(1'b1, DMACON_ADDR, 16'h1FFF);   // clear all
    cpu_access(1'b0, DMACONR_ADDR, 16'h0000);
    // a full line with random disk slots across the refresh window
    repeat (LINE_SLOTS + 20) begin
      @(posedge clk);
      r = $random(seed);
      dsk_dma <= r[0];
      {dsk_wr, dsk_reg_address, dsk_address} <= r[29:1];
    end
    @(posedge clk);
    clear_requests();
    // random requests under random channel enables
    repeat (5) begin
      cpu_access(1'b1, DMACON_ADDR, 16'h1FFF);
      r = $random(seed);
      cpu_access(1'b1, DMACON_ADDR, {3'b100, r[12:0]});
      repeat (80) begin
        @(posedge clk);
        randomize_requests();
      end
      @(posedge clk);
      clear_requests();
    end
    // blitter slowdown
    cpu_access(1'b1, DMACON_ADDR, 16'h1FFF);
    cpu_access(1'b1, DMACON_ADDR, 16'h8240);   // master and blitter only
    bls     <= 1'b1;
    blt_req <= 1'b1;
    blt_we  <= 1'b1;
    repeat (12) @(posedge clk);
    turbo <= 1'b1;                             // every slot counts
    bls   <= 1'b0;                             // one slot to empty the count
    @(posedge clk);
    bls   <= 1'b1;
    repeat (8) @(posedge clk);
    turbo   <= 1'b0;
    blt_req <= 1'b0;
    cpu_access(1'b1, DMACON_ADDR, 16'h8400);   // nasty mode back on
    blt_req <= 1'b1;
    repeat (10) @(posedge clk);
    blt_req <= 1'b0;
    cpu_access(1'b1, DMACON_ADDR, 16'h0400);
    blt_req <= 1'b1;
    repeat (12) @(posedge clk);
    bls <= 1'b0;                               // cpu no longer starved
    repeat (10) @(posedge clk);
    clear_requests();
    repeat (2) @(posedge clk);
    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
    $display("run timed out before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
  --top-module tb_agnus -o sim_agnus || exit 1
out=$(./obj_dir/sim_agnus)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && echo "run passed" \
  || { echo "run failed"; exit 1; }

/* src/agnus_top.sv */
`timescale 1ns/1ps

module agnus_top (
  input  logic                                clk,
  input  logic                                reset,
  // cpu register bus
  input  logic                                aen,
  input  logic                                rd,
  input  logic                                hwr,
  input  logic                                lwr,
  input  chip_bus_pkg::reg_addr_t             address_in,
  input  chip_bus_pkg::data_word_t            data_in,
  output chip_bus_pkg::data_word_t            data_out,
  // chip bus
  output chip_bus_pkg::chip_addr_t            address_out,
  output chip_bus_pkg::reg_addr_t             reg_address_out,
  output logic                                cpu_custom,
  output logic                                dbr,
  output logic                                dbwe,
  output logic [chipset_regs_pkg::HPOS_W-1:0] hpos,
  output logic                                bltpri,
  // blitter status and throttle
  input  logic                                blit_busy,
  input  logic                                blit_zero,
  input  logic                                bls,
  input  logic                                turbo,
  // disk, audio, bitplane slots
  input  logic                                dsk_dma,
  input  chip_bus_pkg::chip_addr_t            dsk_address,
  input  chip_bus_pkg::reg_addr_t             dsk_reg_address,
  input  logic                                dsk_wr,
  input  logic                                aud_dma,
  input  chip_bus_pkg::chip_addr_t            aud_address,
  input  chip_bus_pkg::reg_addr_t             aud_reg_address,
  input  logic                                bpl_dma,
  input  chip_bus_pkg::chip_addr_t            bpl_address,
  input  chip_bus_pkg::reg_addr_t             bpl_reg_address,
  // sprite, copper, blitter request/ack
  input  logic                                spr_req,
  input  chip_bus_pkg::chip_addr_t            spr_address,
  input  chip_bus_pkg::reg_addr_t             spr_reg_address,
  output logic                                spr_ack,
  input  logic                                cop_req,
  input  chip_bus_pkg::chip_addr_t            cop_address,
  input  chip_bus_pkg::reg_addr_t             cop_reg_address,
  output logic                                cop_ack,
  input  logic                                blt_req,
  input  chip_bus_pkg::chip_addr_t            blt_address,
  input  chip_bus_pkg::reg_addr_t             blt_reg_address,
  input  logic                                blt_we,
  output logic                                blt_ack
);
  import chip_bus_pkg::*;

  logic      refresh;          // refresh slot flag
  logic      bplen;
  logic      copen;
  logic      blten;
  logic      spren;
  reg_addr_t cpu_reg_address;  // cpu side of the register bus
  reg_addr_t reg_address;      // selected register, seen by dma_control

  dma_bus_if dsk_bus ();
  dma_bus_if aud_bus ();
  dma_bus_if bpl_bus ();
  dma_bus_if spr_bus ();
  dma_bus_if cop_bus ();
  dma_bus_if blt_bus ();

  // cpu address decode, idle unless a bus cycle is running
  assign cpu_reg_address = (aen && (rd || hwr || lwr)) ? address_in : REG_IDLE;
  assign reg_address_out = reg_address;

  // ------------------------------------------------------------------
  // pack plain request ports into channel buses
  // ------------------------------------------------------------------

  assign dsk_bus.valid       = dsk_dma;
  assign dsk_bus.address     = dsk_address;
  assign dsk_bus.reg_address = dsk_reg_address;
  assign dsk_bus.write       = dsk_wr;
  assign aud_bus.valid       = aud_dma;
  assign aud_bus.address     = aud_address;
  assign aud_bus.reg_address = aud_reg_address;
  assign aud_bus.write       = 1'b0;             // read only channel
  assign bpl_bus.valid       = bpl_dma;
  assign bpl_bus.address     = bpl_address;
  assign bpl_bus.reg_address = bpl_reg_address;
  assign bpl_bus.write       = 1'b0;
  assign spr_bus.valid       = spr_req;
  assign spr_bus.address     = spr_address;
  assign spr_bus.reg_address = spr_reg_address;
  assign spr_bus.write       = 1'b0;
  assign cop_bus.valid       = cop_req;
  assign cop_bus.address     = cop_address;
  assign cop_bus.reg_address = cop_reg_address;
  assign cop_bus.write       = 1'b0;
  assign blt_bus.valid       = blt_req;
  assign blt_bus.address     = blt_address;
  assign blt_bus.reg_address = blt_reg_address;
  assign blt_bus.write       = blt_we;

  assign spr_ack = spr_bus.ready;
  assign cop_ack = cop_bus.ready;
  assign blt_ack = blt_bus.ready;

  // ------------------------------------------------------------------
  // blocks
  // ------------------------------------------------------------------

  beam_slot_counter u_beam (
    .clk     (clk),
    .reset   (reset),
    .hpos    (hpos),
    .refresh (refresh)
  );

  dma_control u_dmacon (
    .clk         (clk),
    .reset       (reset),
    .reg_address (reg_address),
    .data_in     (data_in),
    .blit_busy   (blit_busy),
    .blit_zero   (blit_zero),
    .data_out    (data_out),
    .bplen       (bplen),
    .copen       (copen),
    .blten       (blten),
    .spren       (spren),
    .bltpri      (bltpri)
  );

  bus_arbiter u_arb (
    .clk             (clk),
    .reset           (reset),
    .hpos            (hpos),
    .refresh         (refresh),
    .turbo           (turbo),
    .bls             (bls),
    .bplen           (bplen),
    .copen           (copen),
    .blten           (blten),
    .spren           (spren),
    .bltpri          (bltpri),
    .cpu_reg_address (cpu_reg_address),
    .dsk             (dsk_bus.arbiter),
    .aud             (aud_bus.arbiter),
    .bpl             (bpl_bus.arbiter),
    .spr             (spr_bus.arbiter),
    .cop             (cop_bus.arbiter),
    .blt             (blt_bus.arbiter),
    .address_out     (address_out),
    .reg_address     (reg_address),
    .cpu_custom      (cpu_custom),
    .dbr             (dbr),
    .dbwe            (dbwe)
  );

endmodule

/* src/beam_slot_counter.sv */
`timescale 1ns/1ps

module beam_slot_counter (
  input  logic                                clk,
  input  logic                                reset,
  output logic [chipset_regs_pkg::HPOS_W-1:0] hpos,     // bus slot in line
  output logic                                refresh   // memory refresh slot
);
  import chipset_regs_pkg::*;

  logic              line_end;    // last slot of the line
  logic [HPOS_W-1:0] ref_offset;  // distance from first refresh slot

  assign line_end = (hpos == HPOS_W'(LINE_SLOTS - 1));

  // ------------------------------------------------------------------
  // horizontal slot counter, one slot per clk
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset)
      hpos <= '0;
    else if (line_end)
      hpos <= '0;                      // wrap to start of next line
    else
      hpos <= hpos + HPOS_W'(1);
  end

  // refresh takes every other slot starting at REFRESH_SLOT_FIRST
  // offset wraps around below the first slot, so the lower bound is kept
  assign ref_offset = hpos - HPOS_W'(REFRESH_SLOT_FIRST);

  assign refresh = (hpos >= HPOS_W'(REFRESH_SLOT_FIRST)) &&
                   !ref_offset[0] &&    // same phase as first slot
                   (ref_offset[HPOS_W-1:1] < (HPOS_W-1)'(REFRESH_SLOT_COUNT));

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [chipset_regs_pkg::HPOS_W-1:0] hpos,
  input  logic                                refresh,          // refresh slot
  input  logic                                turbo,            // count every slot
  input  logic                                bls,              // cpu missed the bus
  input  logic                                bplen,
  input  logic                                copen,
  input  logic                                blten,
  input  logic                                spren,
  input  logic                                bltpri,
  input  chip_bus_pkg::reg_addr_t             cpu_reg_address,
  dma_bus_if.arbiter                          dsk,
  dma_bus_if.arbiter                          aud,
  dma_bus_if.arbiter                          bpl,
  dma_bus_if.arbiter                          spr,
  dma_bus_if.arbiter                          cop,
  dma_bus_if.arbiter                          blt,
  output chip_bus_pkg::chip_addr_t            address_out,
  output chip_bus_pkg::reg_addr_t             reg_address,
  output logic                                cpu_custom,       // cpu owns the bus
  output logic                                dbr,              // agnus owns the bus
  output logic                                dbwe              // dma memory write
);
  import chip_bus_pkg::*;
  import chipset_regs_pkg::*;

  logic                 cck;       // colour clock phase, odd slots
  logic [BLS_CNT_W-1:0] bls_cnt;   // consecutive missed cpu cycles
  logic                 bls_hold;  // blitter held off
  dma_chan_e            owner;     // bus owner this cycle

  assign cck      = hpos[0];
  assign bls_hold = (bls_cnt == BLS_CNT_W'(BLS_CNT_MAX));

  // ------------------------------------------------------------------
  // blitter slowdown counter
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      bls_cnt <= '0;
    end else if (!cck || turbo) begin    // even slots, or all with turbo
      if (!bls || bltpri)
        bls_cnt <= '0;                   // cpu got through, or nasty mode
      else if (!bls_hold)
        bls_cnt <= bls_cnt + BLS_CNT_W'(1);  // saturates at max
    end
  end

  // ------------------------------------------------------------------
  // fixed priority, first active source wins
  // ------------------------------------------------------------------

  always_comb begin
    if (dsk.valid)
      owner = CHAN_DSK;
    else if (refresh)
      owner = CHAN_REF;
    else if (aud.valid)
      owner = CHAN_AUD;
    else if (bpl.valid && bplen)
      owner = CHAN_BPL;
    else if (spr.valid && spren)
      owner = CHAN_SPR;
    else if (cop.valid && copen)
      owner = CHAN_COP;
    else if (blt.valid && blten && !bls_hold)
      owner = CHAN_BLT;
    else
      owner = CHAN_CPU;                  // nothing else wants the slot
  end

  // ------------------------------------------------------------------
  // address, register address and write multiplexer
  // ------------------------------------------------------------------

  always_comb begin
    address_out = '0;
    reg_address = REG_IDLE;
    dbwe        = 1'b0;
    case (owner)
      CHAN_DSK: begin
        address_out = dsk.address;
        reg_address = dsk.reg_address;
        dbwe        = dsk.write;         // disk may write memory
      end
      CHAN_REF: begin
        address_out = '0;                // refresh, no register target
      end
      CHAN_AUD: begin
        address_out = aud.address;
        reg_address = aud.reg_address;
      end
      CHAN_BPL: begin
        address_out = bpl.address;
        reg_address = bpl.reg_address;
      end
      CHAN_SPR: begin
        address_out = spr.address;
        reg_address = spr.reg_address;
      end
      CHAN_COP: begin
        address_out = cop.address;
        reg_address = cop.reg_address;
      end
      CHAN_BLT: begin
        address_out = blt.address;
        reg_address = blt.reg_address;
        dbwe        = blt.write;         // blitter may write memory
      end
      default: begin
        reg_address = cpu_reg_address;   // cpu register access passes through
      end
    endcase
  end

  assign dbr        = (owner != CHAN_CPU);
  assign cpu_custom = (owner == CHAN_CPU);

  // grants, same cycle as the winning request
  assign dsk.ready = (owner == CHAN_DSK);
  assign aud.ready = (owner == CHAN_AUD);
  assign bpl.ready = (owner == CHAN_BPL);
  assign spr.ready = (owner == CHAN_SPR);
  assign cop.ready = (owner == CHAN_COP);
  assign blt.ready = (owner == CHAN_BLT);

endmodule

/* src/chip_bus_pkg.sv */
package chip_bus_pkg;

  // ------------------------------------------------------------------
  // chip bus widths
  // ------------------------------------------------------------------

  localparam int CHIP_ADDR_W = 20;  // word address bits 20..1
  localparam int REG_ADDR_W  = 8;   // 256 custom registers
  localparam int DATA_W      = 16;  // data bus

  // chip memory word address, byte bit 0 not carried
  typedef logic [CHIP_ADDR_W:1] chip_addr_t;

  // custom register word address
  typedef logic [REG_ADDR_W:1]  reg_addr_t;

  typedef logic [DATA_W-1:0]    data_word_t;

  // no register selected on the register bus
  localparam reg_addr_t REG_IDLE = '1;

  // ------------------------------------------------------------------
  // bus owners, highest priority first
  // ------------------------------------------------------------------

  typedef enum logic [2:0] {
    CHAN_DSK = 3'd0,  // disk dma, never held off
    CHAN_REF = 3'd1,  // memory refresh slots
    CHAN_AUD = 3'd2,  // audio dma
    CHAN_BPL = 3'd3,  // bitplane dma
    CHAN_SPR = 3'd4,  // sprite dma
    CHAN_COP = 3'd5,  // copper
    CHAN_BLT = 3'd6,  // blitter, subject to slowdown
    CHAN_CPU = 3'd7   // bus left to the cpu
  } dma_chan_e;

endpackage

/* src/chipset_regs_pkg.sv */
package chipset_regs_pkg;

  // ------------------------------------------------------------------
  // custom register word addresses
  // ------------------------------------------------------------------

  localparam chip_bus_pkg::reg_addr_t DMACON_ADDR  = 8'h4B;  // byte 0x096
  localparam chip_bus_pkg::reg_addr_t DMACONR_ADDR = 8'h01;  // byte 0x002

  // ------------------------------------------------------------------
  // DMACON layout
  // ------------------------------------------------------------------

  localparam int DMACON_W   = 13;  // stored bits 12..0
  localparam int BLTPRI_BIT = 10;  // blitter nasty
  localparam int DMAEN_BIT  = 9;   // master enable
  localparam int BPLEN_BIT  = 8;
  localparam int COPEN_BIT  = 7;
  localparam int BLTEN_BIT  = 6;
  localparam int SPREN_BIT  = 5;
  localparam int SETCLR_BIT = 15;  // in the written word only

  // ------------------------------------------------------------------
  // line timing
  // ------------------------------------------------------------------

  localparam int HPOS_W             = 9;
  localparam int LINE_SLOTS         = 454;  // bus slots per video line
  localparam int REFRESH_SLOT_FIRST = 9;    // refresh on odd slots 9..15
  localparam int REFRESH_SLOT_COUNT = 4;

  // blitter slowdown, missed cpu cycles before the blitter backs off
  localparam int BLS_CNT_MAX = 3;
  localparam int BLS_CNT_W   = 2;

endpackage

/* src/dma_bus_if.sv */
`timescale 1ns/1ps

// one dma channel's request toward the chip bus arbiter
interface dma_bus_if;
  import chip_bus_pkg::*;

  chip_addr_t address;      // chip memory word address
  reg_addr_t  reg_address;  // destination register of the fetched word
  logic       write;        // memory write cycle (disk and blitter only)
  logic       valid;        // channel wants this slot
  logic       ready;        // slot granted in this same cycle

  // dma engine side
  modport source (
    output address, reg_address, write, valid,
    input  ready
  );

  // arbiter side
  modport arbiter (
    input  address, reg_address, write, valid,
    output ready
  );

endinterface

/* src/dma_control.sv */
`timescale 1ns/1ps

module dma_control (
  input  logic                     clk,
  input  logic                     reset,
  input  chip_bus_pkg::reg_addr_t  reg_address,  // selected register on the bus
  input  chip_bus_pkg::data_word_t data_in,
  input  logic                     blit_busy,    // blitter status for readback
  input  logic                     blit_zero,
  output chip_bus_pkg::data_word_t data_out,
  output logic                     bplen,
  output logic                     copen,
  output logic                     blten,
  output logic                     spren,
  output logic                     bltpri        // blitter nasty
);
  import chipset_regs_pkg::*;

  logic [DMACON_W-1:0] dmacon;    // dma control register
  logic [DMACON_W-1:0] wr_mask;   // bits touched by a write
  logic                wr_sel;    // DMACON addressed this cycle
  logic                rd_sel;    // DMACONR addressed this cycle

  assign wr_mask = data_in[DMACON_W-1:0];
  assign wr_sel  = (reg_address == DMACON_ADDR);
  assign rd_sel  = (reg_address == DMACONR_ADDR);

  // ------------------------------------------------------------------
  // DMACON set/clear write
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      dmacon <= '0;                     // all channels off
    end else if (wr_sel) begin
      if (data_in[SETCLR_BIT])
        dmacon <= dmacon | wr_mask;     // set the marked bits
      else
        dmacon <= dmacon & ~wr_mask;    // clear the marked bits
    end
  end

  // DMACONR readback, zero top bit then blitter status
  assign data_out = rd_sel ? {1'b0, blit_busy, blit_zero, dmacon} : '0;

  // ------------------------------------------------------------------
  // channel enables, gated by the master bit
  // ------------------------------------------------------------------

  assign bplen  = dmacon[BPLEN_BIT] & dmacon[DMAEN_BIT];
  assign copen  = dmacon[COPEN_BIT] & dmacon[DMAEN_BIT];
  assign blten  = dmacon[BLTEN_BIT] & dmacon[DMAEN_BIT];
  assign spren  = dmacon[SPREN_BIT] & dmacon[DMAEN_BIT];
  assign bltpri = dmacon[BLTPRI_BIT];   // not gated by master enable

endmodule
